// File: all.f
verilog/uart_pkg.sv
verilog/uart_baud_counter.sv
verilog/uart_sync_fifo.sv
verilog/rs232_in_deserializer.sv
verilog/rs232_out_serializer.sv
verilog/rs232_communicator.sv
verif/rs232_communicator_chk.sv
verif/rs232_communicator_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the RS232 communicator testbench with Verilator and run it.
# Exits nonzero if the build fails, the simulation fails or the log reports failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module rs232_communicator_tb -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '** FAIL **' "$LOG"; then
	echo "simulation reported failure, see $LOG"
	exit 1
fi

exit 0

// File: verif/rs232_communicator_chk.sv
// Concurrent assertions bound to the RS232 communicator
// Idle line level, receive port hold, values after reset

module rs232_communicator_chk
	import uart_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input logic       to_uart_ready,
	input uart_data_t from_uart_data,
	input logic       from_uart_error,
	input logic       from_uart_valid,
	input logic       from_uart_ready,
	input logic       uart_txd,
	input tx_state_t  tx_state
);

	timeunit 1ns;
	timeprecision 1ps;

	// Line rests high whenever no frame is in flight
	txd_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
		(tx_state == TX_IDLE) |-> uart_txd)
		else $error("uart_txd low while the serializer is idle");

	// Stalled word must not change under the consumer
	rx_word_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(from_uart_valid && !from_uart_ready) |=>
		($stable(from_uart_data) && $stable(from_uart_error)))
		else $error("receive word changed while stalled");

	// One cycle into reset everything is back at rest
	reset_values: assert property (@(posedge clk)
		!rst_n |=> (to_uart_ready && !from_uart_valid && uart_txd && (tx_state == TX_IDLE)))
		else $error("outputs not at reset values");

endmodule

bind rs232_communicator rs232_communicator_chk u_chk (
	.clk             (clk),
	.rst_n           (rst_n),
	.to_uart_ready   (to_uart_ready),
	.from_uart_data  (from_uart_data),
	.from_uart_error (from_uart_error),
	.from_uart_valid (from_uart_valid),
	.from_uart_ready (from_uart_ready),
	.uart_txd        (uart_txd),
	.tx_state        (u_serializer.state)
);

// File: verif/rs232_communicator_tb.sv
// Testbench for the RS232 communicator
// Clock, reset, serial line driver and transmit frame decoder
// Directed tests for both directions, watchdog and summary

module rs232_communicator_tb
	import uart_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD   = 4;
	localparam int BIT_CYCLES   = int'(BAUD_TICK_COUNT);
	localparam int HALF_CYCLES  = int'(HALF_BAUD_TICK_COUNT);
	localparam int FRAME_CYCLES = FRAME_BITS * BIT_CYCLES;
	localparam int DEPTH        = int'(FIFO_DEPTH);
	// Frames on both lines over all tests plus slack
	localparam int TOTAL_FRAMES = 1 + DEPTH + 4 + 2 + 20;
	localparam int WATCHDOG_NS  = (TOTAL_FRAMES + 10) * FRAME_CYCLES * CLK_PERIOD;

	logic       clk;
	logic       rst_n;
	uart_data_t to_uart_data;
	logic       to_uart_valid;
	logic       to_uart_ready;
	uart_data_t from_uart_data;
	logic       from_uart_error;
	logic       from_uart_valid;
	logic       from_uart_ready;
	logic       uart_rxd;
	logic       uart_txd;

	int          checks;
	int          errors;
	logic [31:0] rng_state;
	logic        tx_full_seen;

	// Bytes accepted, bytes decoded, bytes expected back
	uart_data_t tx_sent[$];
	uart_data_t tx_seen[$];
	uart_data_t rx_sent[$];

	rs232_communicator u_dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.to_uart_data    (to_uart_data),
		.to_uart_valid   (to_uart_valid),
		.to_uart_ready   (to_uart_ready),
		.from_uart_data  (from_uart_data),
		.from_uart_error (from_uart_error),
		.from_uart_valid (from_uart_valid),
		.from_uart_ready (from_uart_ready),
		.uart_rxd        (uart_rxd),
		.uart_txd        (uart_txd)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic uart_data_t random_byte();
		rng_state = xorshift32(rng_state);
		return rng_state[7:0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("ERROR: %s at %0t", what, $time);
	endtask

	// One bit period on uart_rxd
	task automatic drive_rx_bit(input logic value);
		@(posedge clk);
		uart_rxd <= value;
		repeat (BIT_CYCLES - 1) @(posedge clk);
	endtask

	task automatic send_rx_frame(input uart_data_t data, input logic stop_bit);
		drive_rx_bit(1'b0);
		for (int i = 0; i < 8; i++) begin
			drive_rx_bit(data[i]);
		end
		drive_rx_bit(stop_bit);
	endtask

	// Sends count random frames and expects back only the first keep
	task automatic send_rx_batch(input int count, input int keep, input logic stop_bit);
		uart_data_t b;
		rx_sent.delete();
		for (int i = 0; i < count; i++) begin
			b = random_byte();
			if (i < keep) begin
				rx_sent.push_back(b);
			end
			send_rx_frame(b, stop_bit);
		end
	endtask

	// Decode one frame at mid-bit
	task automatic read_tx_frame(output uart_data_t data, output logic ok);
		int waited;
		waited = 0;
		ok = 1'b0;
		data = '0;
		do begin
			@(negedge clk);
			waited++;
		end while (uart_txd !== 1'b0 && waited < 2 * FRAME_CYCLES);
		if (uart_txd !== 1'b0) begin
			report_failure("no start bit appeared on uart_txd");
			return;
		end
		repeat (HALF_CYCLES) @(negedge clk);
		check_value("uart_txd start bit", 32'(uart_txd), 32'd0);
		for (int i = 0; i < 8; i++) begin
			repeat (BIT_CYCLES) @(negedge clk);
			data[i] = uart_txd;
		end
		repeat (BIT_CYCLES) @(negedge clk);
		check_value("uart_txd stop bit", 32'(uart_txd), 32'd1);
		ok = 1'b1;
	endtask

	task automatic collect_tx_frames(input int count);
		uart_data_t b;
		logic ok;
		tx_seen.delete();
		for (int i = 0; i < count; i++) begin
			read_tx_frame(b, ok);
			if (!ok) begin
				return;
			end
			tx_seen.push_back(b);
		end
	endtask

	// Push random bytes until limit or until ready drops
	task automatic push_bytes(input int limit);
		uart_data_t b;
		tx_sent.delete();
		tx_full_seen = 1'b0;
		b = random_byte();
		@(posedge clk);
		to_uart_valid <= 1'b1;
		to_uart_data  <= b;
		forever begin
			@(negedge clk);
			if (!to_uart_ready) begin
				tx_full_seen = 1'b1;
				@(posedge clk);
				break;
			end
			// Handshake completes on the coming edge
			tx_sent.push_back(b);
			@(posedge clk);
			if (tx_sent.size() == limit) begin
				break;
			end
			b = random_byte();
			to_uart_data <= b;
		end
		to_uart_valid <= 1'b0;
	endtask

	task automatic compare_tx_order();
		check_value("tx frame count", 32'(tx_seen.size()), 32'(tx_sent.size()));
		for (int i = 0; i < tx_seen.size() && i < tx_sent.size(); i++) begin
			check_value("uart_txd data", 32'(tx_seen[i]), 32'(tx_sent[i]));
		end
	endtask

	// Pop every expected word with one handshake each
	task automatic expect_rx_words(input logic exp_err);
		int waited;
		foreach (rx_sent[i]) begin
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
			end while (!from_uart_valid && waited < 2 * FRAME_CYCLES);
			if (!from_uart_valid) begin
				report_failure("from_uart_valid never rose for an expected word");
				return;
			end
			check_value("from_uart_data", 32'(from_uart_data), 32'(rx_sent[i]));
			check_value("from_uart_error", 32'(from_uart_error), 32'(exp_err));
			@(posedge clk);
			from_uart_ready <= 1'b1;
			@(posedge clk);
			from_uart_ready <= 1'b0;
		end
	endtask

	task automatic test_reset_state();
		int low_samples;
		low_samples = 0;
		@(negedge clk);
		check_value("to_uart_ready", 32'(to_uart_ready), 32'd1);
		check_value("from_uart_valid", 32'(from_uart_valid), 32'd0);
		repeat (64) begin
			@(negedge clk);
			if (uart_txd !== 1'b1) begin
				low_samples++;
			end
		end
		check_value("uart_txd idle low samples", 32'(low_samples), 32'd0);
		$display("test reset_state finished, %0d errors so far", errors);
	endtask

	task automatic test_single_tx();
		fork
			push_bytes(1);
			collect_tx_frames(1);
		join
		compare_tx_order();
		$display("test single_tx finished, %0d errors so far", errors);
	endtask

	// Previous stop bit still on the line keeps the shifter busy during the burst
	// Only the FIFO fills, so DEPTH bytes go in before ready drops
	task automatic test_tx_backpressure();
		fork
			push_bytes(40);
			collect_tx_frames(DEPTH);
		join
		check_value("to_uart_ready dropped", 32'(tx_full_seen), 32'd1);
		check_value("accepted byte count", 32'(tx_sent.size()), 32'(DEPTH));
		compare_tx_order();
		$display("test tx_backpressure finished, %0d errors so far", errors);
	endtask

	task automatic test_rx_stalled();
		send_rx_batch(4, 4, 1'b1);
		repeat (BIT_CYCLES) @(posedge clk);
		expect_rx_words(1'b0);
		$display("test rx_stalled finished, %0d errors so far", errors);
	endtask

	task automatic test_rx_framing_error();
		send_rx_batch(1, 1, 1'b0);
		// Back to idle so the next start edge is clean
		drive_rx_bit(1'b1);
		expect_rx_words(1'b1);
		$display("test rx_framing_error finished, %0d errors so far", errors);
	endtask

	task automatic test_rx_overflow();
		send_rx_batch(20, DEPTH, 1'b1);
		expect_rx_words(1'b0);
		@(negedge clk);
		check_value("from_uart_valid after drain", 32'(from_uart_valid), 32'd0);
		$display("test rx_overflow finished, %0d errors so far", errors);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests completed");
		$display("** FAIL **");
		$finish;
	end

	initial begin
		checks          = 0;
		errors          = 0;
		rng_state       = 32'hf4a2;
		tx_full_seen    = 1'b0;
		rst_n           = 1'b0;
		to_uart_data    = '0;
		to_uart_valid   = 1'b0;
		from_uart_ready = 1'b0;
		uart_rxd        = 1'b1;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		test_reset_state();
		test_single_tx();
		test_tx_backpressure();
		test_rx_stalled();
		test_rx_framing_error();
		test_rx_overflow();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: verilog/rs232_communicator.sv
// RS232 communicator top level
// Streaming transmit and receive ports to the board's serial pins

module rs232_communicator
	import uart_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  uart_data_t to_uart_data,
	input  logic       to_uart_valid,
	output logic       to_uart_ready,
	output uart_data_t from_uart_data,
	output logic       from_uart_error,
	output logic       from_uart_valid,
	input  logic       from_uart_ready,
	input  logic       uart_rxd,
	output logic       uart_txd
);

	fifo_level_t tx_space;
	rx_word_t    rx_word;

	// Accept while the transmit FIFO has room
	assign to_uart_ready = |tx_space;

	rs232_out_serializer u_serializer (
		.clk      (clk),
		.rst_n    (rst_n),
		.tx_data  (to_uart_data),
		.tx_push  (to_uart_valid && to_uart_ready),
		.tx_space (tx_space),
		.uart_txd (uart_txd)
	);

	// Pop on handshake, head holds otherwise
	rs232_in_deserializer u_deserializer (
		.clk      (clk),
		.rst_n    (rst_n),
		.uart_rxd (uart_rxd),
		.rx_pop   (from_uart_valid && from_uart_ready),
		.rx_word  (rx_word),
		.rx_avail (from_uart_valid)
	);

	// Error flag marks a bad stop bit
	assign from_uart_data  = rx_word.data;
	assign from_uart_error = rx_word.framing_err;

endmodule

// File: verilog/rs232_in_deserializer.sv
// RS232 receive path
// Line synchronizer, 8N1 receive FSM and receive FIFO
// Framing error stored alongside each byte

module rs232_in_deserializer
	import uart_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     uart_rxd,
	input  logic     rx_pop,
	output rx_word_t rx_word,
	output logic     rx_avail
);

	// Synchronizer and edge detect flops
	logic rxd_meta;
	logic rxd_sync;
	logic rxd_prev;
	logic rxd_fall;

	rx_state_t  state;
	logic [2:0] bit_cnt;
	uart_data_t shreg;

	logic restart;
	logic bit_tick;
	logic half_tick;

	logic     push;
	logic     fifo_full;
	logic     fifo_empty;
	rx_word_t word_in;

	// Line idles high
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= uart_rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	assign rxd_fall = rxd_prev && !rxd_sync;

	// Align counter to the start edge, then to mid-bit
	// so every later bit_tick lands mid-bit
	assign restart = ((state == RX_IDLE) && rxd_fall) ||
			((state == RX_START) && half_tick);

	uart_baud_counter u_baud (
		.clk       (clk),
		.rst_n     (rst_n),
		.restart   (restart),
		.bit_tick  (bit_tick),
		.half_tick (half_tick)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= RX_IDLE;
			bit_cnt <= '0;
		end else begin
			case (state)
				RX_IDLE: begin
					if (rxd_fall) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					bit_cnt <= '0;
					// High again at mid-bit means a glitch
					if (half_tick) begin
						state <= rxd_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (bit_tick) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= RX_STOP;
						end
					end
				end
				RX_STOP: begin
					if (bit_tick) begin
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// LSB arrives first, shift in from the top
	always_ff @(posedge clk) begin
		if ((state == RX_DATA) && bit_tick) begin
			shreg <= {rxd_sync, shreg[7:1]};
		end
	end

	// Stop-bit sample, low stop is a framing error
	assign push                = (state == RX_STOP) && bit_tick;
	assign word_in.data        = shreg;
	assign word_in.framing_err = !rxd_sync;

	// Line cannot stall, word lost when full
	uart_sync_fifo #(
		.WIDTH ($bits(rx_word_t))
	) u_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en   (push && !fifo_full),
		.wr_data (word_in),
		.rd_en   (rx_pop),
		.rd_data (rx_word),
		.empty   (fifo_empty),
		.full    (fifo_full),
		.space   ()
	);

	assign rx_avail = !fifo_empty;

endmodule

// File: verilog/rs232_out_serializer.sv
// RS232 transmit path
// Transmit FIFO, 10-bit frame shifter and transmit FSM
// Frames go out back to back while bytes are queued

module rs232_out_serializer
	import uart_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  uart_data_t  tx_data,
	input  logic        tx_push,
	output fifo_level_t tx_space,
	output logic        uart_txd
);

	tx_state_t state;

	// Stop, data, start; bit 0 is the line
	logic [FRAME_BITS-1:0] frame;
	logic [3:0]            bit_cnt;

	uart_data_t fifo_head;
	logic       fifo_empty;

	logic load;
	logic frame_done;
	logic bit_tick;

	// Tenth tick ends the stop bit
	assign frame_done = (state == TX_SHIFT) && bit_tick &&
			(bit_cnt == 4'(FRAME_BITS - 1));

	// Pop when idle or right at the end of a frame
	assign load = !fifo_empty && ((state == TX_IDLE) || frame_done);

	uart_sync_fifo #(
		.WIDTH ($bits(uart_data_t))
	) u_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en   (tx_push),
		.wr_data (tx_data),
		.rd_en   (load),
		.rd_data (fifo_head),
		.empty   (fifo_empty),
		.full    (),
		.space   (tx_space)
	);

	// Only the bit period is needed here
	uart_baud_counter u_baud (
		.clk       (clk),
		.rst_n     (rst_n),
		.restart   (load),
		.bit_tick  (bit_tick),
		.half_tick ()
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= TX_IDLE;
			frame   <= '1;
			bit_cnt <= '0;
		end else if (load) begin
			// Start bit appears on the next cycle
			state   <= TX_SHIFT;
			frame   <= {1'b1, fifo_head, 1'b0};
			bit_cnt <= '0;
		end else if (frame_done) begin
			// Frame already shifted down to all ones
			state <= TX_IDLE;
		end else if ((state == TX_SHIFT) && bit_tick) begin
			frame   <= {1'b1, frame[FRAME_BITS-1:1]};
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// Straight from a flop, high when idle
	assign uart_txd = frame[0];

endmodule

// File: verilog/uart_baud_counter.sv
// Bit-period counter for the RS232 communicator
// Restartable, flags the mid-bit and end-of-bit points

module uart_baud_counter
	import uart_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic restart,
	output logic bit_tick,
	output logic half_tick
);

	// Runs 1 .. BAUD_TICK_COUNT
	baud_count_t count;

	// End of the bit period
	assign bit_tick = (count == BAUD_TICK_COUNT);

	// Middle of the bit period
	assign half_tick = (count == HALF_BAUD_TICK_COUNT);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= baud_count_t'(1);
		end else if (restart || bit_tick) begin
			// Reload, next cycle is the first of a new period
			count <= baud_count_t'(1);
		end else begin
			count <= count + 1'b1;
		end
	end

endmodule

// File: verilog/uart_pkg.sv
// Shared definitions for the RS232 communicator
// Bit timing, FIFO sizing, data types and FSM encodings

package uart_pkg;

	// Bit period in clk cycles
	typedef logic [8:0] baud_count_t;

	// 434 cycles per bit
	localparam baud_count_t BAUD_TICK_COUNT = 9'd434;
	// Mid-bit sample point
	localparam baud_count_t HALF_BAUD_TICK_COUNT = 9'd217;

	// Start + 8 data + stop
	localparam int FRAME_BITS = 10;

	// One data byte
	typedef logic [7:0] uart_data_t;

	// FIFO addressing, 16 entries
	localparam int FIFO_AW = 4;

	// Free space, 0 to 16 inclusive
	typedef logic [FIFO_AW:0] fifo_level_t;

	localparam fifo_level_t FIFO_DEPTH = fifo_level_t'(2 ** FIFO_AW);

	// Receive FIFO entry
	typedef struct packed {
		uart_data_t data;
		logic framing_err;
	} rx_word_t;

	// Transmit FSM
	typedef enum logic {
		TX_IDLE,
		TX_SHIFT
	} tx_state_t;

	// Receive FSM
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

endpackage

// File: verilog/uart_sync_fifo.sv
// Show-ahead synchronous FIFO, 16 entries
// Head word always on rd_data
// Reports empty, full and free space

module uart_sync_fifo
	import uart_pkg::*;
#(
	parameter int WIDTH = 8
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             empty,
	output logic             full,
	output fifo_level_t      space
);

	// Storage array
	logic [WIDTH-1:0] mem [FIFO_DEPTH];

	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;

	// Occupied entries
	fifo_level_t count;

	logic do_wr;
	logic do_rd;

	// Drop writes when full, reads when empty
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	assign empty = (count == '0);
	assign full  = (count == FIFO_DEPTH);
	assign space = FIFO_DEPTH - count;

	// Head of queue
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap naturally
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Read and write together leave count alone
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule
